/* hdl/supercpu_pkg.sv */
/*
 * Memory map, widths, region tag indices and reset values
 * for the accelerator decode core
 */
package supercpu_pkg;

    // Widths --------------------
    localparam int ADDR_W = 24;                 // 65816 full address
    localparam int OFFS_W = 16;                 // In-bank offset
    localparam int BANK_W = ADDR_W - OFFS_W;    // Bank byte
    localparam int DATA_W = 8;

    // Register window, bank 0 only
    localparam logic [15:0] REGS_START  = 16'hD070;
    localparam logic [15:0] REGS_END    = 16'hD07F;
    localparam logic [15:0] REG_CONFIG  = 16'hD070; // Bit 0 turbo, bit 1 bridge enable
    localparam logic [15:0] REG_BASE_LO = 16'hD071;
    localparam logic [15:0] REG_BASE_HI = 16'hD072;
    localparam logic [15:0] REG_BANK    = 16'hD073;
    localparam logic [15:0] REG_UNLOCK  = 16'hD07E; // Always decoded
    localparam logic [15:0] REG_LOCK    = 16'hD07F; // Always decoded

    // Bridge window --------------------
    localparam logic [15:0] BRIDGE_SIZE       = 16'd192;
    localparam logic [15:0] BRIDGE_LOW_LIMIT  = 16'h0200; // Keep off zero page and stack
    localparam logic [15:0] IO_START          = 16'hD000; // Bank-0 window ends below I/O
    localparam logic [15:0] BRIDGE_BASE_RESET = 16'h033C; // Cassette buffer

    // Target memory sizes
    localparam int BRIDGE_RAM_AW = 8;
    localparam int SUPER_RAM_AW  = 12;          // 4 KiB, aliased over banks $01-$FF

    // One-hot region tag --------------------
    localparam int REGION_W      = 4;
    localparam int REGION_REGS   = 0;
    localparam int REGION_BRIDGE = 1;
    localparam int REGION_RAM    = 2;
    localparam int REGION_EXT    = 3;

endpackage

/* hdl/mem_access_if.sv */
/*
 * One accepted CPU access, decoder to targets
 */
interface mem_access_if;
    import supercpu_pkg::*;

    logic                     valid;
    logic                     we;
    logic [ADDR_W-1:0]        addr;
    logic [DATA_W-1:0]        wdata;
    logic [REGION_W-1:0]      region;          // One-hot target select
    logic [BRIDGE_RAM_AW-1:0] bridge_offset;   // Offset from window base

    // Decoder side
    modport decoder (
        output valid, we, addr, wdata, region, bridge_offset
    );

    // Register file, RAMs and read return
    modport target (
        input valid, we, addr, wdata, region, bridge_offset
    );

endinterface

/* hdl/address_decoder.sv */
/*
 * Request stage: region decode with bridge safety masks,
 * registers the access into the access interface
 */
module address_decoder (
    input  logic                            clk_20,
    input  logic                            rst_n,
    input  logic                            cpu_valid,
    input  logic                            cpu_we,
    input  logic [supercpu_pkg::ADDR_W-1:0] cpu_addr,
    input  logic [supercpu_pkg::DATA_W-1:0] cpu_wdata,
    input  logic                            regs_enabled,
    input  logic                            bridge_enable,
    input  logic [supercpu_pkg::OFFS_W-1:0] bridge_base,
    input  logic [supercpu_pkg::BANK_W-1:0] bridge_bank,
    mem_access_if.decoder                   acc,
    output logic                            bridge_active
);
    import supercpu_pkg::*;

    logic [BANK_W-1:0]   req_bank;
    logic [OFFS_W-1:0]   req_offs;
    logic [OFFS_W:0]     win_end;      // One bit wider, window never wraps
    logic [OFFS_W-1:0]   win_delta;
    logic                win_legal;
    logic                bridge_hit;
    logic                regs_hit;
    logic [REGION_W-1:0] region_d;

    assign req_bank = cpu_addr[ADDR_W-1:OFFS_W];
    assign req_offs = cpu_addr[OFFS_W-1:0];

    // Bridge window --------------------
    assign win_end = {1'b0, bridge_base} + {1'b0, BRIDGE_SIZE};

    // Nonzero bank is always safe
    // Bank 0 must clear zero page, stack and the I/O area
    assign win_legal = (bridge_bank != '0) ||
                       ((bridge_base >= BRIDGE_LOW_LIMIT) && (win_end < {1'b0, IO_START}));

    assign bridge_active = bridge_enable && win_legal;

    assign bridge_hit = bridge_active &&
                        (req_bank == bridge_bank) &&
                        (req_offs >= bridge_base) &&
                        ({1'b0, req_offs} < win_end);

    assign win_delta = req_offs - bridge_base;   // Below 192 on a hit

    // Unlock and lock stay visible while hidden
    assign regs_hit = (req_offs == REG_UNLOCK) ||
                      (req_offs == REG_LOCK) ||
                      (regs_enabled && (req_offs >= REGS_START) && (req_offs <= REGS_END));

    // Region priority --------------------
    always_comb begin
        region_d = '0;
        if (bridge_hit) begin
            region_d[REGION_BRIDGE] = 1'b1;     // Shadows SuperRAM too
        end else if (req_bank != '0) begin
            region_d[REGION_RAM] = 1'b1;
        end else if (regs_hit) begin
            region_d[REGION_REGS] = 1'b1;
        end else begin
            region_d[REGION_EXT] = 1'b1;        // Rest of bank 0 to C64 bus
        end
    end

    // Access stage
    always_ff @(posedge clk_20) begin
        if (!rst_n) begin
            acc.valid  <= 1'b0;
            acc.region <= '0;
        end else begin
            acc.valid  <= cpu_valid;
            acc.region <= region_d;
        end
    end

    always_ff @(posedge clk_20) begin
        acc.we            <= cpu_we;
        acc.addr          <= cpu_addr;
        acc.wdata         <= cpu_wdata;
        acc.bridge_offset <= win_delta[BRIDGE_RAM_AW-1:0];
    end

endmodule

/* hdl/control_registers.sv */
/*
 * $D070-$D07F register file, unlock/lock,
 * turbo bit and bridge window configuration
 */
module control_registers (
    input  logic                            clk_20,
    input  logic                            rst_n,
    mem_access_if.target                    acc,
    output logic [supercpu_pkg::DATA_W-1:0] regs_rdata,
    output logic                            regs_enabled,
    output logic                            turbo_mode,
    output logic                            bridge_enable,
    output logic [supercpu_pkg::OFFS_W-1:0] bridge_base,
    output logic [supercpu_pkg::BANK_W-1:0] bridge_bank
);
    import supercpu_pkg::*;

    logic [DATA_W-1:0] config_q;
    logic [OFFS_W-1:0] reg_offs;
    logic              reg_wr;
    logic              reg_rd;
    logic [DATA_W-1:0] rd_mux;

    assign reg_offs = acc.addr[OFFS_W-1:0];
    assign reg_wr   = acc.valid && acc.region[REGION_REGS] && acc.we;
    assign reg_rd   = acc.valid && acc.region[REGION_REGS] && !acc.we;

    // Write side --------------------
    always_ff @(posedge clk_20) begin
        if (!rst_n) begin
            regs_enabled <= 1'b0;              // Registers hidden
            config_q     <= '0;
            bridge_base  <= BRIDGE_BASE_RESET;
            bridge_bank  <= '0;
        end else if (reg_wr) begin
            case (reg_offs)
                REG_UNLOCK:  regs_enabled      <= 1'b1; // Data byte ignored
                REG_LOCK:    regs_enabled      <= 1'b0;
                REG_CONFIG:  config_q          <= acc.wdata;
                REG_BASE_LO: bridge_base[7:0]  <= acc.wdata;
                REG_BASE_HI: bridge_base[15:8] <= acc.wdata;
                REG_BANK:    bridge_bank       <= acc.wdata;
                default: ;                      // Spare slots
            endcase
        end
    end

    assign turbo_mode    = config_q[0];
    assign bridge_enable = config_q[1];

    // Read side --------------------
    always_comb begin
        case (reg_offs)
            REG_CONFIG:  rd_mux = config_q;
            REG_BASE_LO: rd_mux = bridge_base[7:0];
            REG_BASE_HI: rd_mux = bridge_base[15:8];
            REG_BANK:    rd_mux = bridge_bank;
            default:     rd_mux = '0;           // Unlock, lock, spares
        endcase
    end

    // Byte ready one cycle after the access stage
    always_ff @(posedge clk_20) begin
        if (reg_rd) begin
            regs_rdata <= rd_mux;
        end
    end

endmodule

/* hdl/bridge_window_ram.sv */
/*
 * Bridge window store, indexed by offset from the window base
 */
module bridge_window_ram (
    input  logic                            clk_20,
    mem_access_if.target                    acc,
    output logic [supercpu_pkg::DATA_W-1:0] bridge_rdata
);
    import supercpu_pkg::*;

    // 256 entries, decoder keeps the offset under 192
    logic [DATA_W-1:0] mem [2**BRIDGE_RAM_AW];
    logic              hit;

    assign hit = acc.valid && acc.region[REGION_BRIDGE];

    always_ff @(posedge clk_20) begin
        if (hit) begin
            if (acc.we) begin
                mem[acc.bridge_offset] <= acc.wdata;
            end
            bridge_rdata <= mem[acc.bridge_offset];   // Old byte on a write, unused
        end
    end

endmodule

/* hdl/super_ram.sv */
/*
 * SuperRAM for banks $01-$FF, aliased into 4 KiB
 */
module super_ram (
    input  logic                            clk_20,
    mem_access_if.target                    acc,
    output logic [supercpu_pkg::DATA_W-1:0] ram_rdata
);
    import supercpu_pkg::*;

    logic [DATA_W-1:0]       mem [2**SUPER_RAM_AW];
    logic [SUPER_RAM_AW-1:0] ram_idx;
    logic                    hit;

    assign ram_idx = acc.addr[SUPER_RAM_AW-1:0];   // Bank and high offset bits drop out
    assign hit     = acc.valid && acc.region[REGION_RAM];

    always_ff @(posedge clk_20) begin
        if (hit) begin
            if (acc.we) begin
                mem[ram_idx] <= acc.wdata;
            end
            ram_rdata <= mem[ram_idx];
        end
    end

endmodule

/* hdl/read_return.sv */
/*
 * External C64 bus request and read data return,
 * two cycles from request to cpu_rvalid
 */
module read_return (
    input  logic                            clk_20,
    input  logic                            rst_n,
    mem_access_if.target                    acc,
    input  logic [supercpu_pkg::DATA_W-1:0] regs_rdata,
    input  logic [supercpu_pkg::DATA_W-1:0] bridge_rdata,
    input  logic [supercpu_pkg::DATA_W-1:0] ram_rdata,
    input  logic [supercpu_pkg::DATA_W-1:0] ext_rdata,
    output logic                            ext_req,
    output logic                            ext_we,
    output logic [supercpu_pkg::OFFS_W-1:0] ext_addr,
    output logic [supercpu_pkg::DATA_W-1:0] ext_wdata,
    output logic [supercpu_pkg::DATA_W-1:0] cpu_rdata,
    output logic                            cpu_rvalid
);
    import supercpu_pkg::*;

    logic                rd_pend;      // Read in the target stage
    logic [REGION_W-1:0] rd_region;
    logic [DATA_W-1:0]   ext_rdata_q;
    logic [DATA_W-1:0]   rdata_sel;

    // External bus --------------------
    assign ext_req   = acc.valid && acc.region[REGION_EXT];
    assign ext_we    = ext_req && acc.we;
    assign ext_addr  = acc.addr[OFFS_W-1:0];   // Bank 0 only
    assign ext_wdata = acc.wdata;

    // Target stage, C64 byte captured with the internal targets
    always_ff @(posedge clk_20) begin
        if (!rst_n) begin
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= acc.valid && !acc.we;
        end
    end

    always_ff @(posedge clk_20) begin
        rd_region <= acc.region;
        if (ext_req && !acc.we) begin
            ext_rdata_q <= ext_rdata;
        end
    end

    // Return stage --------------------
    always_comb begin
        if (rd_region[REGION_REGS]) begin
            rdata_sel = regs_rdata;
        end else if (rd_region[REGION_BRIDGE]) begin
            rdata_sel = bridge_rdata;
        end else if (rd_region[REGION_RAM]) begin
            rdata_sel = ram_rdata;
        end else begin
            rdata_sel = ext_rdata_q;          // Region ext
        end
    end

    always_ff @(posedge clk_20) begin
        if (!rst_n) begin
            cpu_rvalid <= 1'b0;
        end else begin
            cpu_rvalid <= rd_pend;            // One-cycle pulse per read
        end
    end

    always_ff @(posedge clk_20) begin
        cpu_rdata <= rdata_sel;
    end

endmodule

/* hdl/supercpu_top.sv */
/*
 * Decode and memory-mapping core top level
 */
module supercpu_top (
    input  logic                            clk_20,
    input  logic                            rst_n,
    // CPU request
    input  logic                            cpu_valid,
    input  logic                            cpu_we,
    input  logic [supercpu_pkg::ADDR_W-1:0] cpu_addr,
    input  logic [supercpu_pkg::DATA_W-1:0] cpu_wdata,
    // Read return
    output logic [supercpu_pkg::DATA_W-1:0] cpu_rdata,
    output logic                            cpu_rvalid,
    // C64 bus
    output logic                            ext_req,
    output logic                            ext_we,
    output logic [supercpu_pkg::OFFS_W-1:0] ext_addr,
    output logic [supercpu_pkg::DATA_W-1:0] ext_wdata,
    input  logic [supercpu_pkg::DATA_W-1:0] ext_rdata,
    // Status
    output logic                            turbo_mode,
    output logic                            bridge_active
);
    import supercpu_pkg::*;

    logic              regs_enabled;
    logic              bridge_enable;
    logic [OFFS_W-1:0] bridge_base;
    logic [BANK_W-1:0] bridge_bank;
    logic [DATA_W-1:0] regs_rdata;
    logic [DATA_W-1:0] bridge_rdata;
    logic [DATA_W-1:0] ram_rdata;

    mem_access_if acc ();

    // Request stage --------------------
    address_decoder i_address_decoder (
        .clk_20        (clk_20),
        .rst_n         (rst_n),
        .cpu_valid     (cpu_valid),
        .cpu_we        (cpu_we),
        .cpu_addr      (cpu_addr),
        .cpu_wdata     (cpu_wdata),
        .regs_enabled  (regs_enabled),
        .bridge_enable (bridge_enable),
        .bridge_base   (bridge_base),
        .bridge_bank   (bridge_bank),
        .acc           (acc),
        .bridge_active (bridge_active)
    );

    // Targets --------------------
    control_registers i_control_registers (
        .clk_20        (clk_20),
        .rst_n         (rst_n),
        .acc           (acc),
        .regs_rdata    (regs_rdata),
        .regs_enabled  (regs_enabled),
        .turbo_mode    (turbo_mode),
        .bridge_enable (bridge_enable),
        .bridge_base   (bridge_base),
        .bridge_bank   (bridge_bank)
    );

    bridge_window_ram i_bridge_window_ram (
        .clk_20       (clk_20),
        .acc          (acc),
        .bridge_rdata (bridge_rdata)
    );

    super_ram i_super_ram (
        .clk_20    (clk_20),
        .acc       (acc),
        .ram_rdata (ram_rdata)
    );

    // External bus and return --------------------
    read_return i_read_return (
        .clk_20       (clk_20),
        .rst_n        (rst_n),
        .acc          (acc),
        .regs_rdata   (regs_rdata),
        .bridge_rdata (bridge_rdata),
        .ram_rdata    (ram_rdata),
        .ext_rdata    (ext_rdata),
        .ext_req      (ext_req),
        .ext_we       (ext_we),
        .ext_addr     (ext_addr),
        .ext_wdata    (ext_wdata),
        .cpu_rdata    (cpu_rdata),
        .cpu_rvalid   (cpu_rvalid)
    );

endmodule

/* dv/tb_supercpu.sv */
/*
 * Testbench for the decode core: clock, reset, directed and random stimulus,
 * reference model, C64 bus memory model, checks and watchdog
 */
module tb_supercpu;
    timeunit 1ns;
    timeprecision 1ps;
    import supercpu_pkg::*;

    localparam int SRAM_FILL = 2**SUPER_RAM_AW;
    localparam int SRAM_RW   = 800;
    localparam int BRIDGE_RW = 300;
    localparam int MIX_N     = 4000;
    localparam int DIRECTED  = 400;              // Register setup, probes, settle cycles
    // A mix step costs at most three cycles
    localparam int MAX_CYCLES = SRAM_FILL + SRAM_RW + 192 + 2 * BRIDGE_RW + 3 * MIX_N + DIRECTED;

    logic              clk_20;
    logic              rst_n;
    logic              cpu_valid;
    logic              cpu_we;
    logic [ADDR_W-1:0] cpu_addr;
    logic [DATA_W-1:0] cpu_wdata;
    logic [DATA_W-1:0] cpu_rdata;
    logic              cpu_rvalid;
    logic              ext_req;
    logic              ext_we;
    logic [OFFS_W-1:0] ext_addr;
    logic [DATA_W-1:0] ext_wdata;
    logic [DATA_W-1:0] ext_rdata;
    logic              turbo_mode;
    logic              bridge_active;

    int                seed = 72459;
    string             test_name;
    logic [DATA_W-1:0] ext_mem    [2**OFFS_W];   // C64 side
    logic [DATA_W-1:0] ref_ext    [2**OFFS_W];
    logic [DATA_W-1:0] ref_bridge [2**BRIDGE_RAM_AW];
    logic [DATA_W-1:0] ref_sram   [2**SUPER_RAM_AW];
    logic              m_regs_en;
    logic [DATA_W-1:0] m_config;
    logic [OFFS_W-1:0] m_base;
    logic [7:0]        m_bank;
    logic              reg_wr_seen;              // Last issue was a register write

    // Expected pipeline over issued, access and target stage
    logic              p_rd   [3];
    logic              p_ext  [3];
    logic              p_we   [3];
    logic [OFFS_W-1:0] p_addr [3];
    logic [DATA_W-1:0] p_wd   [3];
    logic [DATA_W-1:0] p_rdat [3];

    supercpu_top i_supercpu_top (
        .clk_20        (clk_20),
        .rst_n         (rst_n),
        .cpu_valid     (cpu_valid),
        .cpu_we        (cpu_we),
        .cpu_addr      (cpu_addr),
        .cpu_wdata     (cpu_wdata),
        .cpu_rdata     (cpu_rdata),
        .cpu_rvalid    (cpu_rvalid),
        .ext_req       (ext_req),
        .ext_we        (ext_we),
        .ext_addr      (ext_addr),
        .ext_wdata     (ext_wdata),
        .ext_rdata     (ext_rdata),
        .turbo_mode    (turbo_mode),
        .bridge_active (bridge_active)
    );

    initial begin
        clk_20 = 1'b0;
        forever #10 clk_20 = ~clk_20;
    end

    function automatic logic [DATA_W-1:0] ext_pattern(input logic [OFFS_W-1:0] a);
        return a[7:0] ^ a[15:8] ^ 8'hA5;         // Folds both address bytes
    endfunction

    // C64 bus memory --------------------
    assign ext_rdata = ext_mem[ext_addr];        // Combinational read
    initial begin
        for (int i = 0; i < 2**OFFS_W; i++) begin
            ext_mem[i] = ext_pattern(16'(i));
        end
        forever begin
            @(posedge clk_20);
            if (ext_req && ext_we) begin
                ext_mem[ext_addr] = ext_wdata;
            end
        end
    end

    initial begin
        #((MAX_CYCLES + 100) * 20);
        $display("=== FAIL ===");
        $fatal(1, "Timeout after %0d cycles, the test sequence did not finish", MAX_CYCLES + 100);
    end

    function automatic logic [31:0] rnd(input logic [31:0] n);
        logic [31:0] r;
        r = $random(seed);
        return r % n;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH test=%s %s expected=%0h actual=%0h", test_name, what, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "Wrong value on %s", what);
        end
    endtask

    // Reference model --------------------
    function automatic logic bridge_on();
        int b;
        b = int'(m_base);
        // Nonzero bank always safe, bank 0 between $0200 and the I/O area
        return m_config[1] && ((m_bank != 8'h00) || ((b >= 'h200) && (b + 192 < 'hD000)));
    endfunction

    function automatic logic [DATA_W-1:0] reg_value(input logic [OFFS_W-1:0] offs);
        case (offs)
            REG_CONFIG:  return m_config;
            REG_BASE_LO: return m_base[7:0];
            REG_BASE_HI: return m_base[15:8];
            REG_BANK:    return m_bank;
            default:     return 8'h00;           // Unlock, lock, spares
        endcase
    endfunction

    // Shift expectations and compare with what the DUT shows now
    task automatic retire_and_check();
        logic              exp_rd;
        logic [DATA_W-1:0] exp_dat;
        exp_rd  = p_rd[2];
        exp_dat = p_rdat[2];
        for (int s = 2; s > 0; s--) begin
            p_rd[s]   = p_rd[s-1];
            p_ext[s]  = p_ext[s-1];
            p_we[s]   = p_we[s-1];
            p_addr[s] = p_addr[s-1];
            p_wd[s]   = p_wd[s-1];
            p_rdat[s] = p_rdat[s-1];
        end
        if (exp_rd != cpu_rvalid) begin
            $display("=== FAIL ===");
            if (exp_rd) begin
                $fatal(1, "A read in test %s never raised cpu_rvalid", test_name);
            end else begin
                $fatal(1, "cpu_rvalid rose in test %s with no read outstanding", test_name);
            end
        end
        if (exp_rd) begin
            check_value("cpu_rdata", 32'(exp_dat), 32'(cpu_rdata));
        end
        check_value("ext_req", 32'(p_ext[1]), 32'(ext_req));
        if (p_ext[1]) begin
            check_value("ext_addr", 32'(p_addr[1]), 32'(ext_addr));
            check_value("ext_we", 32'(p_we[1]), 32'(ext_we));
            if (p_we[1]) begin
                check_value("ext_wdata", 32'(p_wd[1]), 32'(ext_wdata));
            end
        end
    endtask

    // One cycle of checking, model decode and driving 2 ns after the edge
    task automatic issue(input logic v, input logic we, input logic [ADDR_W-1:0] a,
                         input logic [DATA_W-1:0] d);
        logic [7:0]        bank;
        logic [OFFS_W-1:0] offs;
        logic [OFFS_W-1:0] delta;
        logic              hit;
        int                o;
        int                b;
        @(posedge clk_20);
        #2;
        retire_and_check();
        reg_wr_seen = 1'b0;
        bank  = a[23:16];
        offs  = a[15:0];
        o     = int'(offs);
        b     = int'(m_base);
        hit   = bridge_on() && (bank == m_bank) && (o >= b) && (o < b + 192);
        delta = offs - m_base;
        p_rd[0]   = v && !we;
        p_ext[0]  = 1'b0;
        p_we[0]   = we;
        p_addr[0] = offs;
        p_wd[0]   = d;
        p_rdat[0] = 8'h00;
        if (!v) begin
            p_rd[0] = 1'b0;                      // Idle
        end else if (hit) begin
            if (we) ref_bridge[delta[7:0]] = d;
            else p_rdat[0] = ref_bridge[delta[7:0]];
        end else if (bank != 8'h00) begin
            if (we) ref_sram[a[11:0]] = d;       // 4 KiB alias
            else p_rdat[0] = ref_sram[a[11:0]];
        end else if ((offs == REG_UNLOCK) || (offs == REG_LOCK) ||
                     (m_regs_en && (offs >= REGS_START) && (offs <= REGS_END))) begin
            if (we) begin
                reg_wr_seen = 1'b1;
                case (offs)
                    REG_UNLOCK:  m_regs_en    = 1'b1;
                    REG_LOCK:    m_regs_en    = 1'b0;
                    REG_CONFIG:  m_config     = d;
                    REG_BASE_LO: m_base[7:0]  = d;
                    REG_BASE_HI: m_base[15:8] = d;
                    REG_BANK:    m_bank       = d;
                    default: ;
                endcase
            end else begin
                p_rdat[0] = reg_value(offs);
            end
        end else begin
            p_ext[0] = 1'b1;                     // C64 bus
            if (we) ref_ext[offs] = d;
            else p_rdat[0] = ref_ext[offs];
        end
        cpu_valid = v;
        cpu_we    = we;
        cpu_addr  = a;
        cpu_wdata = d;
    endtask

    task automatic idle(input int n);
        repeat (n) issue(1'b0, 1'b0, '0, '0);
    endtask

    // Register writes settle two cycles before the next request
    task automatic access(input logic we, input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        issue(1'b1, we, a, d);
        if (reg_wr_seen) begin
            idle(2);
            check_value("turbo_mode", 32'(m_config[0]), 32'(turbo_mode));
            check_value("bridge_active", 32'(bridge_on()), 32'(bridge_active));
        end
    endtask

    task automatic mix_step();
        logic [31:0]       sel;
        logic [31:0]       r1;
        logic [31:0]       r2;
        logic [31:0]       r3;
        logic [31:0]       r4;
        logic [31:0]       r5;
        logic              we;
        logic [OFFS_W-1:0] offs;
        sel = rnd(8);
        r1  = rnd(255);
        r2  = rnd(65536);
        r3  = rnd(256);
        r4  = rnd(200);
        r5  = rnd(2);
        we  = r5[0];
        case (sel)
            0, 1: access(we, {r1[7:0] + 8'd1, r2[15:0]}, r3[7:0]);     // SuperRAM
            2, 3: begin
                offs = m_base - 16'd4 + r4[15:0];                      // Around the window
                access(we, {m_bank, offs}, r3[7:0]);
            end
            4: access(we, {8'h00, r2[15:0]}, r3[7:0]);                 // Bank 0
            5: begin
                offs = REGS_START + {12'h000, r4[3:0]};
                if (offs == REG_BANK) access(we, {8'h00, offs}, {6'b0, r3[1:0]});
                else access(we, {8'h00, offs}, r3[7:0]);
            end
            default: idle(1 + int'(r4[0]));
        endcase
    endtask

    // Test sequence --------------------
    initial begin
        rst_n     = 1'b0;
        cpu_valid = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        for (int i = 0; i < 2**OFFS_W; i++) begin
            ref_ext[i] = ext_pattern(16'(i));
        end
        for (int s = 0; s < 3; s++) begin
            p_rd[s]   = 1'b0;
            p_ext[s]  = 1'b0;
            p_we[s]   = 1'b0;
            p_addr[s] = '0;
            p_wd[s]   = '0;
            p_rdat[s] = '0;
        end
        m_regs_en   = 1'b0;                      // Reset state
        m_config    = 8'h00;
        m_base      = 16'h033C;
        m_bank      = 8'h00;
        reg_wr_seen = 1'b0;
        repeat (3) @(posedge clk_20);
        #2;
        rst_n = 1'b1;

        test_name = "reset";
        check_value("turbo_mode", 32'd0, 32'(turbo_mode));
        check_value("bridge_active", 32'd0, 32'(bridge_active));
        access(1'b0, 24'h00D070, 8'h00);         // Hidden so it goes to the C64 bus

        test_name = "unlock_lock";
        access(1'b1, 24'h00D07E, 8'h00);
        access(1'b1, 24'h00D070, 8'h01);         // Turbo only
        access(1'b1, 24'h00D071, 8'h00);
        access(1'b1, 24'h00D072, 8'h40);         // Base $4000
        access(1'b1, 24'h00D073, 8'h00);
        access(1'b1, 24'h00D070, 8'h03);         // Turbo and bridge
        for (int i = 0; i < 16; i++) begin
            access(1'b0, 24'h00D070 + 24'(i), 8'h00);
        end
        access(1'b1, 24'h00D07F, 8'h00);
        access(1'b0, 24'h00D070, 8'h00);         // External again

        test_name = "super_ram";
        for (int i = 0; i < SRAM_FILL; i++) begin
            access(1'b1, 24'h010000 + 24'(i), 8'(rnd(256)));
        end
        for (int i = 0; i < SRAM_RW; i++) begin
            mix_step_ram();
        end

        test_name = "bridge";
        for (int i = 0; i < 192; i++) begin
            access(1'b1, 24'h004000 + 24'(i), 8'(rnd(256)));
        end
        for (int i = 0; i < BRIDGE_RW; i++) begin
            access(rnd(2) == 1, 24'h004000 + 24'(rnd(192)), 8'(rnd(256)));
        end
        access(1'b0, 24'h003FFF, 8'h00);         // Just outside
        access(1'b0, 24'h0040C0, 8'h00);
        access(1'b1, 24'h00D07E, 8'h00);
        access(1'b1, 24'h00D072, 8'h80);
        access(1'b1, 24'h00D073, 8'h05);         // Window at $058000
        for (int i = 0; i < BRIDGE_RW / 2; i++) begin
            access(rnd(2) == 1, 24'h058000 + 24'(rnd(192)), 8'(rnd(256)));
        end
        access(1'b0, 24'h057FFF, 8'h00);         // SuperRAM neighbours
        access(1'b0, 24'h0580C0, 8'h00);
        access(1'b0, 24'h008000, 8'h00);

        test_name = "safety";
        access(1'b1, 24'h00D073, 8'h00);
        access(1'b1, 24'h00D072, 8'h01);         // Base $0100 below the limit
        check_value("bridge_active", 32'd0, 32'(bridge_active));
        access(1'b0, 24'h000100, 8'h00);
        access(1'b0, 24'h000150, 8'h00);
        access(1'b1, 24'h00D072, 8'hCF);
        access(1'b1, 24'h00D071, 8'h40);         // Ends at $D000
        check_value("bridge_active", 32'd0, 32'(bridge_active));
        access(1'b0, 24'h00CF40, 8'h00);
        access(1'b0, 24'h00CFFF, 8'h00);

        test_name = "random_mix";
        access(1'b1, 24'h00D072, 8'h20);         // Legal bank 0 window to start
        for (int i = 0; i < MIX_N; i++) begin
            mix_step();
        end
        idle(3);                                 // Drain the pipeline
        $display("=== PASS ===");
        $finish;
    end

    task automatic mix_step_ram();
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = rnd(255);
        r2 = rnd(65536);
        access(rnd(2) == 1, {r1[7:0] + 8'd1, r2[15:0]}, 8'(rnd(256)));
    endtask

endmodule

/* sources.f */
hdl/supercpu_pkg.sv
hdl/mem_access_if.sv
hdl/address_decoder.sv
hdl/control_registers.sv
hdl/bridge_window_ram.sv
hdl/super_ram.sv
hdl/read_return.sv
hdl/supercpu_top.sv
dv/tb_supercpu.sv

/* run.sh */
#!/bin/sh
# Compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_supercpu -f sources.f -Mdir obj_dir -o tb_supercpu
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_supercpu
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0
